/* source/rf_pg_pkg.sv */
//------------------------------------------------
// Geometry and shared types of the 16x160 power
// gated register file. The depth must stay a power
// of two so that the address type covers it fully
//------------------------------------------------

package rf_pg_pkg;

    //------------------------------------------------
    // Array geometry
    //------------------------------------------------

    // Number of rows in the array
    localparam int rf_depth = 16;

    // Data bits held by one row
    localparam int rf_width = 160;

    //------------------------------------------------
    // Types
    //------------------------------------------------

    // Row index wide enough for every entry
    typedef logic [$clog2(rf_depth)-1:0] rf_addr_t;

    // One full row of data
    typedef logic [rf_width-1:0] rf_data_t;

    // Power sequencer states
    // Off means gated, init means clearing rows, on means usable
    typedef enum logic [1:0] {
        pwr_off  = 2'd0,
        pwr_init = 2'd1,
        pwr_on   = 2'd2
    } pwr_state_t;

endpackage

/* source/rf_array.sv */
//------------------------------------------------
// Two-port storage of 16 rows by 160 bits. Write
// port on wclk, registered read port on rclk.
// Rows hold no defined value until the wake-up
// clear of the power sequencer zeroes them
//------------------------------------------------

`timescale 1ns/1ps

module rf_array (
    // Write port in the wclk domain
     input  logic                wclk
    ,input  logic                rst_n
    ,input  logic                we
    ,input  rf_pg_pkg::rf_addr_t waddr
    ,input  rf_pg_pkg::rf_data_t wdata

    // Permission and row clear from the power sequencer
    ,input  logic                wr_allow
    ,input  logic                init_en
    ,input  rf_pg_pkg::rf_addr_t init_addr

    // Read port in the rclk domain
    ,input  logic                rclk
    ,input  logic                re
    ,input  rf_pg_pkg::rf_addr_t raddr
    ,output rf_pg_pkg::rf_data_t rd_raw
);

    import rf_pg_pkg::*;

    //------------------------------------------------
    // Storage
    //------------------------------------------------

    // The row array itself, modelled as flops
    rf_data_t mem [rf_depth];

    // Read output register
    rf_data_t rd_q;

    //------------------------------------------------
    // Write port
    //------------------------------------------------

    // The init clear wins over a functional write
    // A functional write only lands while the sequencer reports power on
    always_ff @(posedge wclk) begin
        if (init_en) begin
            mem[init_addr] <= '0;
        end else if (we && wr_allow) begin
            mem[waddr] <= wdata;
        end
    end

    //------------------------------------------------
    // Read port
    //------------------------------------------------

    // The addressed row is captured on the rclk edge that samples re
    // With aligned clocks a same-cycle write is not yet visible, so the old value is returned
    // The register holds its value until the next read
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (re) begin
            rd_q <= mem[raddr];
        end
    end

    // Raw data goes on to the read gate, which applies the clamp
    assign rd_raw = rd_q;

endmodule

/* source/rf_power_ctrl.sv */
//------------------------------------------------
// Power-gate sequencer in the wclk domain. A low
// request starts a clear of every row, one per
// cycle, and power good follows the last row.
// A high request drops to off from any state
//------------------------------------------------

`timescale 1ns/1ps

module rf_power_ctrl (
     input  logic                wclk
    ,input  logic                rst_n

    // Low requests power
    ,input  logic                pwr_enable_b_in

    // Row clear towards the array
    ,output logic                init_en
    ,output rf_pg_pkg::rf_addr_t init_addr

    // High only while the array is usable
    ,output logic                wr_allow

    // Low means powered and initialized
    ,output logic                pwr_enable_b_out
);

    import rf_pg_pkg::*;

    //------------------------------------------------
    // State and row counter
    //------------------------------------------------

    // Index of the last row, where the clear ends
    localparam rf_addr_t last_row = rf_addr_t'(rf_depth - 1);

    pwr_state_t state_q;
    pwr_state_t state_nxt;

    // Row being cleared during init
    rf_addr_t   row_q;
    rf_addr_t   row_nxt;

    //------------------------------------------------
    // Next state
    //------------------------------------------------

    always_comb begin
        state_nxt = state_q;
        row_nxt   = row_q;

        case (state_q)
            pwr_off: begin
                // Start the wake-up clear at row 0
                if (!pwr_enable_b_in) begin
                    state_nxt = pwr_init;
                    row_nxt   = '0;
                end
            end

            pwr_init: begin
                if (pwr_enable_b_in) begin
                    // Request withdrawn part way through the clear
                    state_nxt = pwr_off;
                    row_nxt   = '0;
                end else if (row_q == last_row) begin
                    // The edge that clears the last row also grants power
                    state_nxt = pwr_on;
                    row_nxt   = '0;
                end else begin
                    row_nxt = row_q + rf_addr_t'(1);
                end
            end

            pwr_on: begin
                if (pwr_enable_b_in) begin
                    state_nxt = pwr_off;
                end
            end

            default: begin
                // An unused encoding falls back to off
                state_nxt = pwr_off;
                row_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            state_q <= pwr_off;
            row_q   <= '0;
        end else begin
            state_q <= state_nxt;
            row_q   <= row_nxt;
        end
    end

    //------------------------------------------------
    // Outputs
    //------------------------------------------------

    // One row is cleared on each wclk edge spent in init
    assign init_en   = (state_q == pwr_init);
    assign init_addr = row_q;

    // Writes are only honoured once the clear has finished
    assign wr_allow  = (state_q == pwr_on);

    // Power good is active low and follows the on state directly
    assign pwr_enable_b_out = (state_q != pwr_on);

endmodule

/* source/rf_read_gate.sv */
//------------------------------------------------
// Output clamp of the read port. Power status is
// brought into rclk through a flop chain; the
// isolation input clamps without any delay.
// pwr_sync_stages must be 2 or 3
//------------------------------------------------

`timescale 1ns/1ps

module rf_read_gate #(
    parameter int pwr_sync_stages = 2
) (
     input  logic                rclk
    ,input  logic                rst_n

    // Registered array output
    ,input  rf_pg_pkg::rf_data_t rd_raw

    // Power status from the wclk domain, low means powered
    ,input  logic                pwr_enable_b_out

    // High isolates the array outputs
    ,input  logic                pgcb_isol_en

    ,output rf_pg_pkg::rf_data_t rdata
);

    //------------------------------------------------
    // Power status synchronizer
    //------------------------------------------------

    // Flop chain with the oldest sample in the top bit
    logic [pwr_sync_stages-1:0] pwr_sync_q;

    // Status as seen in rclk is high while off or still initializing
    logic                       pwr_off_rclk;

    // The chain resets to "off" so reads stay clamped until power good arrives
    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            pwr_sync_q <= '1;
        end else begin
            pwr_sync_q <= {pwr_sync_q[pwr_sync_stages-2:0], pwr_enable_b_out};
        end
    end

    assign pwr_off_rclk = pwr_sync_q[pwr_sync_stages-1];

    //------------------------------------------------
    // Output clamp
    //------------------------------------------------

    // Models the isolation cells on the array outputs
    // Isolation acts combinationally; power status acts after the synchronizer delay
    always_comb begin
        if (pgcb_isol_en || pwr_off_rclk) begin
            rdata = '0;
        end else begin
            rdata = rd_raw;
        end
    end

endmodule

/* source/rf_pg_subsys.sv */
//------------------------------------------------
// Power-gated 16x160 register file. One rst_n for
// both clocks, held two cycles of each. Writes are
// dropped until power good; reads clamp to zero
// while isolated or unpowered
//------------------------------------------------

`timescale 1ns/1ps

module rf_pg_subsys #(
    // Flops in the rclk synchronizer of the power status
    parameter int pwr_sync_stages = 2
) (
    // Write side
     input  logic                wclk
    ,input  logic                we
    ,input  rf_pg_pkg::rf_addr_t waddr
    ,input  rf_pg_pkg::rf_data_t wdata

    // Read side
    ,input  logic                rclk
    ,input  logic                re
    ,input  rf_pg_pkg::rf_addr_t raddr
    ,output rf_pg_pkg::rf_data_t rdata

    // Power interface
    ,input  logic                pwr_enable_b_in
    ,input  logic                pgcb_isol_en
    ,output logic                pwr_enable_b_out

    ,input  logic                rst_n
);

    import rf_pg_pkg::*;

    //------------------------------------------------
    // Internal connections
    //------------------------------------------------

    // Row clear and write permission from sequencer to array
    logic     init_en;
    rf_addr_t init_addr;
    logic     wr_allow;

    // Unclamped read data from array to gate
    rf_data_t rd_raw;

    //------------------------------------------------
    // Storage array
    //------------------------------------------------

    rf_array u_array (
         .wclk      (wclk)
        ,.rst_n     (rst_n)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.wr_allow  (wr_allow)
        ,.init_en   (init_en)
        ,.init_addr (init_addr)
        ,.rclk      (rclk)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.rd_raw    (rd_raw)
    );

    //------------------------------------------------
    // Power sequencer on the write clock
    //------------------------------------------------

    rf_power_ctrl u_power (
         .wclk             (wclk)
        ,.rst_n            (rst_n)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.init_en          (init_en)
        ,.init_addr        (init_addr)
        ,.wr_allow         (wr_allow)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Read-side clamp
    rf_read_gate #(
        .pwr_sync_stages (pwr_sync_stages)
    ) u_gate (
         .rclk             (rclk)
        ,.rst_n            (rst_n)
        ,.rd_raw           (rd_raw)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.rdata            (rdata)
    );

endmodule

/* verif/tb_rf_pg_subsys.sv */
//------------------------------------------------
// Directed testbench of the power-gated register
// file. wclk and rclk share one 10 ns clock, so
// every latency below is counted in that clock
//------------------------------------------------

`timescale 1ns/1ps

module tb_rf_pg_subsys;

    import rf_pg_pkg::*;

    // Flops in the power status synchronizer of the DUT
    localparam int sync_stages = 2;

    // Cycle limit of every wait loop
    localparam int timeout = 100;

    logic     wclk;
    logic     rclk;
    logic     rst_n;
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;
    logic     pwr_enable_b_in;
    logic     pgcb_isol_en;
    logic     pwr_enable_b_out;

    // Reference rows and whether a write lands in them right now
    rf_data_t    model [rf_depth];
    logic        model_on;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;

    rf_pg_subsys #(
        .pwr_sync_stages (sync_stages)
    ) u_rf_pg_subsys (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.rst_n            (rst_n)
    );

    // Both clocks toggle together with a 10 ns period
    always begin
        #5;
        wclk = ~wclk;
        rclk = wclk;
    end

    //------------------------------------------------
    // Stimulus helpers
    //------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A full row built from five generator words
    function automatic rf_data_t random_row();
        rf_data_t v;
        for (int k = 0; k < rf_width / 32; k++) begin
            v[k*32 +: 32] = lcg_next();
        end
        return v;
    endfunction

    // Top bits of the generator are the most random ones
    function automatic rf_addr_t random_addr();
        logic [31:0] r;
        r = lcg_next();
        return r[31:28];
    endfunction

    // Fixed pattern that carries the whole row index in every word
    function automatic rf_data_t known_row(input rf_addr_t a);
        return {5{{a, 28'hc3a596e}}};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < rf_depth; i++) begin
            model[i] = '0;
        end
    endtask

    // One write strobe, which lands on the edge after it is driven
    task automatic drive_write(input rf_addr_t a, input rf_data_t d);
        @(posedge wclk);
        we    <= 1'b1;
        waddr <= a;
        wdata <= d;
        @(posedge wclk);
        we <= 1'b0;
        if (model_on) begin
            model[a] = d;
        end
    endtask

    // One read strobe, then wait until rdata is stable mid cycle
    task automatic drive_read(input rf_addr_t a);
        @(posedge wclk);
        re    <= 1'b1;
        raddr <= a;
        @(posedge wclk);
        re <= 1'b0;
        @(negedge wclk);
    endtask

    task automatic expect_rdata(input rf_data_t exp, input string what);
        checks++;
        if (rdata !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, rdata %h expected %h", $time, what, rdata, exp);
        end
    endtask

    // Counts wclk edges after the request edge until the status reaches level
    task automatic wait_power_status(input logic level, output int edges);
        edges = 0;
        @(negedge wclk);
        while (pwr_enable_b_out !== level && edges < timeout) begin
            @(negedge wclk);
            edges++;
        end
        if (pwr_enable_b_out !== level) begin
            errors++;
            $display("Timeout at %0t: pwr_enable_b_out never reached %b in %0d cycles (%s)",
                     $time, level, timeout, u_rf_pg_subsys.u_power.state_q.name());
        end
    endtask

    // Power up takes the sampling edge plus one clear edge per row
    // Power down takes only the sampling edge
    task automatic request_power(input logic on);
        int edges;
        int exp_edges;
        exp_edges = on ? rf_depth + 1 : 1;
        @(posedge wclk);
        pwr_enable_b_in <= !on;
        if (!on) begin
            model_on = 1'b0;
        end
        wait_power_status(!on, edges);
        checks++;
        if (edges != exp_edges) begin
            errors++;
            $display("MISMATCH at %0t: power status changed after %0d edges, expected %0d",
                     $time, edges, exp_edges);
        end
        if (on) begin
            clear_model();
            model_on = 1'b1;
        end
        // The read gate sees the new status only after the synchronizer
        repeat (sync_stages) @(posedge rclk);
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - start);
        end
    endtask

    //------------------------------------------------
    // Tests
    //------------------------------------------------

    task automatic check_reset_state();
        int start;
        start = errors;
        @(negedge wclk);
        checks++;
        if (pwr_enable_b_out !== 1'b1) begin
            errors++;
            $display("MISMATCH at %0t: pwr_enable_b_out %b after reset, expected 1",
                     $time, pwr_enable_b_out);
        end
        expect_rdata('0, "rdata after reset");
        // Unpowered rows hold anything, but the gate must clamp them
        drive_write(rf_addr_t'(3), random_row());
        drive_read(rf_addr_t'(3));
        expect_rdata('0, "read while powered off");
        report_test("reset state", start);
    endtask

    task automatic power_up_clear();
        int start;
        start = errors;
        request_power(1'b1);
        for (int i = 0; i < rf_depth; i++) begin
            drive_read(rf_addr_t'(i));
            expect_rdata('0, $sformatf("row %0d after wake", i));
        end
        report_test("power up clear", start);
    endtask

    task automatic random_access();
        int       start;
        rf_addr_t a;
        rf_data_t held;
        rf_data_t new_row;
        start = errors;
        for (int i = 0; i < rf_depth; i++) begin
            drive_write(rf_addr_t'(i), random_row());
        end
        for (int i = 0; i < 24; i++) begin
            a = random_addr();
            drive_read(a);
            expect_rdata(model[a], $sformatf("random read of row %0d", a));
        end
        // With re low the output register keeps the last row read
        // Neither a new value in that row nor a new raddr may reach rdata
        held = model[a];
        drive_write(a, random_row());
        @(posedge wclk);
        raddr <= a + rf_addr_t'(1);
        repeat (2) @(posedge wclk);
        @(negedge wclk);
        expect_rdata(held, "rdata hold with re low");
        // A read in the write cycle of the same row returns the old row
        held    = model[a];
        new_row = random_row();
        @(posedge wclk);
        we    <= 1'b1;
        waddr <= a;
        wdata <= new_row;
        re    <= 1'b1;
        raddr <= a;
        @(posedge wclk);
        we <= 1'b0;
        re <= 1'b0;
        model[a] = new_row;
        @(negedge wclk);
        expect_rdata(held, "read during write of the same row");
        drive_read(a);
        expect_rdata(model[a], "read after same-cycle write");
        report_test("random access", start);
    endtask

    task automatic isolation_clamp();
        int       start;
        rf_addr_t a;
        rf_addr_t b;
        start = errors;
        a = random_addr();
        b = a + rf_addr_t'(5);
        drive_read(a);
        expect_rdata(model[a], "read before isolation");
        @(posedge wclk);
        pgcb_isol_en <= 1'b1;
        @(negedge wclk);
        expect_rdata('0, "rdata under isolation");
        drive_read(b);
        expect_rdata('0, "read under isolation");
        @(posedge wclk);
        pgcb_isol_en <= 1'b0;
        drive_read(b);
        expect_rdata(model[b], "read after isolation release");
        report_test("isolation clamp", start);
    endtask

    task automatic power_cycle();
        int start;
        start = errors;
        for (int i = 0; i < rf_depth; i++) begin
            drive_write(rf_addr_t'(i), known_row(rf_addr_t'(i)));
        end
        drive_read(rf_addr_t'(9));
        expect_rdata(model[9], "known row before power down");
        request_power(1'b0);
        drive_read(rf_addr_t'(9));
        expect_rdata('0, "read while powered down");
        // Writes while off are dropped
        for (int i = 0; i < rf_depth; i++) begin
            drive_write(rf_addr_t'(i), random_row());
        end
        request_power(1'b1);
        for (int i = 0; i < rf_depth; i++) begin
            drive_read(rf_addr_t'(i));
            expect_rdata(model[i], $sformatf("row %0d after power cycle", i));
        end
        report_test("power cycle", start);
    endtask

    //------------------------------------------------
    // Main sequence
    //------------------------------------------------

    initial begin
        wclk            = 1'b0;
        rclk            = 1'b0;
        rst_n           = 1'b0;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        pwr_enable_b_in = 1'b1;
        pgcb_isol_en    = 1'b0;
        lcg_state       = 32'h4cac3998;
        checks          = 0;
        errors          = 0;
        model_on        = 1'b0;
        clear_model();

        repeat (2) @(posedge wclk);
        rst_n <= 1'b1;

        check_reset_state();
        power_up_clear();
        random_access();
        isolation_clamp();
        power_cycle();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
source/rf_pg_pkg.sv
source/rf_array.sv
source/rf_power_ctrl.sv
source/rf_read_gate.sv
source/rf_pg_subsys.sv
verif/tb_rf_pg_subsys.sv

/* Makefile */
# Verilator build, run, lint and clean for the power-gated register file

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_rf_pg_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message appears as a line of its own
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
